// File: logic/tmu_defines.svh
`ifndef TMU_DEFINES_SVH
`define TMU_DEFINES_SVH

// egress ports and traffic classes per port
`define TMU_PORTS      4
`define TMU_TCS        2

// one queue per port and class pair
`define TMU_QUEUES     (`TMU_PORTS * `TMU_TCS)

// tags held per queue
`define TMU_DEPTH      8

// derived widths
`define TMU_PORT_W     $clog2(`TMU_PORTS)
`define TMU_TC_W       $clog2(`TMU_TCS)
`define TMU_QID_W      $clog2(`TMU_QUEUES)
`define TMU_PTR_W      $clog2(`TMU_DEPTH)
// occupancy must reach TMU_DEPTH itself
`define TMU_OCC_W      $clog2(`TMU_DEPTH + 1)

// length in 64B segments, 1..127
`define TMU_LEN_W      7
`define TMU_SEG_CNT_W  10
`define TMU_EOP_CNT_W  4

`endif

// File: logic/tmu_pkg.sv
`include "tmu_defines.svh"

package tmu_pkg;

    // queue number = port * TMU_TCS + tc
    typedef logic [`TMU_QID_W-1:0]     queue_id_t;
    typedef logic [`TMU_PTR_W-1:0]     ptr_t;
    typedef logic [`TMU_OCC_W-1:0]     occ_t;
    typedef logic [`TMU_LEN_W-1:0]     len_t;
    typedef logic [`TMU_SEG_CNT_W-1:0] seg_cnt_t;
    typedef logic [`TMU_EOP_CNT_W-1:0] eop_cnt_t;

    // ring tag, also the stored and released form
    typedef struct packed {
        logic                   valid;
        logic [`TMU_PORT_W-1:0] port;
        logic [`TMU_TC_W-1:0]   tc;
        len_t                   len;
        logic                   eop;
    } tag_t;

    // scheduler pop strobe
    typedef struct packed {
        logic                   valid;
        logic [`TMU_PORT_W-1:0] port;
        logic [`TMU_TC_W-1:0]   tc;
    } pop_req_t;

    // new head length of the popped queue, 0 once empty
    typedef struct packed {
        logic                   valid;
        logic [`TMU_PORT_W-1:0] port;
        logic [`TMU_TC_W-1:0]   tc;
        len_t                   head_len;
    } pfs_update_t;

    // head-of-queue view for the scheduler
    typedef struct packed {
        logic valid;
        logic eop_in_buf;
        len_t len;
    } hoq_info_t;

    function automatic queue_id_t qid_of(logic [`TMU_PORT_W-1:0] port,
                                         logic [`TMU_TC_W-1:0] tc);
        return queue_id_t'(port * `TMU_TCS + tc);
    endfunction

endpackage : tmu_pkg

// File: logic/tag_queue_bank.sv
`include "tmu_defines.svh"

module tag_queue_bank
import tmu_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,

    // write side, one accepted ring tag per cycle
    input  logic                           wr_en,
    input  queue_id_t                      wr_qid,
    input  tag_t                           wr_tag,

    // read side, one accepted pop per cycle
    input  logic                           rd_en,
    input  queue_id_t                      rd_qid,

    output occ_t [`TMU_QUEUES-1:0]         occupancy,
    output tag_t [`TMU_QUEUES-1:0]         head_tag,
    output tag_t [`TMU_QUEUES-1:0]         next_tag
);

    // ------------------------------------------------------------------------
    // storage and pointers
    // ------------------------------------------------------------------------

    // one circular buffer per queue
    tag_t mem [`TMU_QUEUES][`TMU_DEPTH];

    ptr_t [`TMU_QUEUES-1:0] head_ptr;
    ptr_t [`TMU_QUEUES-1:0] tail_ptr;
    occ_t [`TMU_QUEUES-1:0] count;

    logic [`TMU_QUEUES-1:0] wr_hit;
    logic [`TMU_QUEUES-1:0] rd_hit;

    // wrap at depth, depth need not be a power of two
    function automatic ptr_t ptr_inc(ptr_t p);
        return (p == ptr_t'(`TMU_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // decode strobes per queue
    always_comb begin
        for (int q = 0; q < `TMU_QUEUES; q++) begin
            wr_hit[q] = wr_en && (wr_qid == queue_id_t'(q));
            rd_hit[q] = rd_en && (rd_qid == queue_id_t'(q));
        end
    end

    // tag write at tail
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_qid][tail_ptr[wr_qid]] <= wr_tag;
        end
    end

    // pointer and count update, push and pop may hit one queue together
    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            for (int q = 0; q < `TMU_QUEUES; q++) begin
                if (wr_hit[q]) begin
                    tail_ptr[q] <= ptr_inc(tail_ptr[q]);
                end
                if (rd_hit[q]) begin
                    head_ptr[q] <= ptr_inc(head_ptr[q]);
                end
                count[q] <= count[q] + occ_t'(wr_hit[q]) - occ_t'(rd_hit[q]);
            end
        end
    end

    // ------------------------------------------------------------------------
    // head and second entry, read straight from storage
    // ------------------------------------------------------------------------

    always_comb begin
        for (int q = 0; q < `TMU_QUEUES; q++) begin
            // stale entries stay hidden behind count
            head_tag[q] = '0;
            next_tag[q] = '0;
            if (count[q] != '0) begin
                head_tag[q] = mem[q][head_ptr[q]];
            end
            if (count[q] > occ_t'(1)) begin
                next_tag[q] = mem[q][ptr_inc(head_ptr[q])];
            end
        end
    end

    assign occupancy = count;

    // control must never let a queue grow past its depth
    for (genvar q = 0; q < `TMU_QUEUES; q++) begin : g_chk
        a_count_bound: assert property (
            @(posedge clk) disable iff (rst)
            count[q] <= occ_t'(`TMU_DEPTH)
        );
    end

endmodule : tag_queue_bank

// File: logic/queue_stats.sv
`include "tmu_defines.svh"

module queue_stats
import tmu_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst,

    // accepted push and pop, queue taken from port and tc
    input  tag_t                               push_stat,
    input  tag_t                               pop_stat,

    // head tags from the bank
    input  tag_t [`TMU_QUEUES-1:0]             head_tag,

    output seg_cnt_t [`TMU_QUEUES-1:0]         seg_count,
    output eop_cnt_t [`TMU_QUEUES-1:0]         eop_count,
    output hoq_info_t [`TMU_QUEUES-1:0]        hoq_info
);

    queue_id_t push_qid;
    queue_id_t pop_qid;

    logic [`TMU_QUEUES-1:0] push_hit;
    logic [`TMU_QUEUES-1:0] pop_hit;

    // per queue amounts entering and leaving this cycle
    seg_cnt_t [`TMU_QUEUES-1:0] seg_in;
    seg_cnt_t [`TMU_QUEUES-1:0] seg_out;
    eop_cnt_t [`TMU_QUEUES-1:0] eop_in;
    eop_cnt_t [`TMU_QUEUES-1:0] eop_out;

    assign push_qid = qid_of(push_stat.port, push_stat.tc);
    assign pop_qid  = qid_of(pop_stat.port, pop_stat.tc);

    // ------------------------------------------------------------------------
    // counter deltas
    // ------------------------------------------------------------------------

    always_comb begin
        for (int q = 0; q < `TMU_QUEUES; q++) begin
            push_hit[q] = push_stat.valid && (push_qid == queue_id_t'(q));
            pop_hit[q]  = pop_stat.valid && (pop_qid == queue_id_t'(q));

            seg_in[q]  = '0;
            eop_in[q]  = '0;
            seg_out[q] = '0;
            eop_out[q] = '0;
            if (push_hit[q]) begin
                seg_in[q] = seg_cnt_t'(push_stat.len);
                eop_in[q] = eop_cnt_t'(push_stat.eop);
            end
            if (pop_hit[q]) begin
                seg_out[q] = seg_cnt_t'(pop_stat.len);
                eop_out[q] = eop_cnt_t'(pop_stat.eop);
            end
        end
    end

    // add and subtract together when both hit one queue
    always_ff @(posedge clk) begin
        if (rst) begin
            seg_count <= '0;
            eop_count <= '0;
        end else begin
            for (int q = 0; q < `TMU_QUEUES; q++) begin
                seg_count[q] <= seg_count[q] + seg_in[q] - seg_out[q];
                eop_count[q] <= eop_count[q] + eop_in[q] - eop_out[q];
            end
        end
    end

    // ------------------------------------------------------------------------
    // head-of-queue view
    // ------------------------------------------------------------------------

    always_comb begin
        for (int q = 0; q < `TMU_QUEUES; q++) begin
            hoq_info[q].valid      = head_tag[q].valid;
            // some full packet waits in this queue
            hoq_info[q].eop_in_buf = (eop_count[q] != '0);
            hoq_info[q].len        = head_tag[q].len;
        end
    end

    // a pop only removes what an earlier push added
    for (genvar q = 0; q < `TMU_QUEUES; q++) begin : g_chk
        a_no_underflow: assert property (
            @(posedge clk) disable iff (rst)
            pop_hit[q] |-> (seg_count[q] >= seg_out[q]) && (eop_count[q] >= eop_out[q])
        );
    end

endmodule : queue_stats

// File: logic/tmu_ctrl.sv
`include "tmu_defines.svh"

module tmu_ctrl
import tmu_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,

    // ring and scheduler strobes
    input  tag_t                       tag_in,
    input  pop_req_t                   pop_in,

    // bank status
    input  occ_t [`TMU_QUEUES-1:0]     occupancy,
    input  tag_t [`TMU_QUEUES-1:0]     head_tag,
    input  tag_t [`TMU_QUEUES-1:0]     next_tag,

    // bank strobes
    output logic                       wr_en,
    output queue_id_t                  wr_qid,
    output tag_t                       wr_tag,
    output logic                       rd_en,
    output queue_id_t                  rd_qid,

    // accepted push and pop for the counters
    output tag_t                       push_stat,
    output tag_t                       pop_stat,

    output tag_t                       prc_tag,
    output pfs_update_t                pfs_update,
    output logic                       drop,
    output logic                       pop_err
);

    queue_id_t push_qid;
    queue_id_t pop_qid;
    logic      pop_ok;
    logic      push_full;
    logic      push_ok;
    logic      same_q;
    len_t      new_head_len;

    // ------------------------------------------------------------------------
    // accept rules
    // ------------------------------------------------------------------------

    assign push_qid = qid_of(tag_in.port, tag_in.tc);
    assign pop_qid  = qid_of(pop_in.port, pop_in.tc);

    // empty pop is rejected, a push this cycle does not help
    assign pop_ok    = pop_in.valid && (occupancy[pop_qid] != '0);
    assign push_full = (occupancy[push_qid] == occ_t'(`TMU_DEPTH));
    assign same_q    = pop_ok && (pop_qid == push_qid);

    // full queue still takes a push when it is popped this cycle
    assign push_ok = tag_in.valid && (!push_full || same_q);

    assign wr_en  = push_ok;
    assign wr_qid = push_qid;
    assign wr_tag = tag_in;
    assign rd_en  = pop_ok;
    assign rd_qid = pop_qid;

    assign push_stat = push_ok ? tag_in : '0;
    assign pop_stat  = pop_ok ? head_tag[pop_qid] : '0;

    // new head after the pop
    always_comb begin
        new_head_len = '0;
        if (occupancy[pop_qid] > occ_t'(1)) begin
            new_head_len = next_tag[pop_qid].len;
        end else if (push_ok && same_q) begin
            // last tag leaves while a new one lands behind it
            new_head_len = tag_in.len;
        end
    end

    // ------------------------------------------------------------------------
    // registered outputs, valid for one cycle
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            prc_tag    <= '0;
            pfs_update <= '0;
            drop       <= 1'b0;
            pop_err    <= 1'b0;
        end else begin
            prc_tag             <= pop_stat;
            pfs_update.valid    <= pop_ok;
            pfs_update.port     <= pop_in.port;
            pfs_update.tc       <= pop_in.tc;
            pfs_update.head_len <= pop_ok ? new_head_len : '0;
            drop                <= tag_in.valid && !push_ok;
            pop_err             <= pop_in.valid && !pop_ok;
        end
    end

    // full queue only written while it is popped, so it stays full
    a_wr_not_full: assert property (
        @(posedge clk) disable iff (rst)
        wr_en && (occupancy[wr_qid] == occ_t'(`TMU_DEPTH))
            |=> occupancy[$past(wr_qid)] == occ_t'(`TMU_DEPTH)
    );

    // a read always finds a stored tag at the head of its queue
    a_rd_not_empty: assert property (
        @(posedge clk) disable iff (rst)
        rd_en |-> head_tag[rd_qid].valid
    );

    // every pop gets exactly one answer in the next cycle
    a_pop_answer: assert property (
        @(posedge clk) disable iff (rst)
        pop_in.valid |=> (prc_tag.valid ^ pop_err) && (pfs_update.valid == prc_tag.valid)
    );

endmodule : tmu_ctrl

// File: logic/tmu.sv
`include "tmu_defines.svh"

module tmu
import tmu_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst,

    // tag ring and scheduler pops
    input  tag_t                               tag_in,
    input  pop_req_t                           pop_in,

    // to packet read side and scheduler
    output tag_t                               prc_tag,
    output pfs_update_t                        pfs_update,
    output hoq_info_t [`TMU_QUEUES-1:0]        hoq_info,
    output seg_cnt_t [`TMU_QUEUES-1:0]         seg_count,
    output eop_cnt_t [`TMU_QUEUES-1:0]         eop_count,
    output logic                               drop,
    output logic                               pop_err
);

    // ------------------------------------------------------------------------
    // internal wiring
    // ------------------------------------------------------------------------

    logic                   wr_en;
    queue_id_t              wr_qid;
    tag_t                   wr_tag;
    logic                   rd_en;
    queue_id_t              rd_qid;
    occ_t [`TMU_QUEUES-1:0] occupancy;
    tag_t [`TMU_QUEUES-1:0] head_tag;
    tag_t [`TMU_QUEUES-1:0] next_tag;
    tag_t                   push_stat;
    tag_t                   pop_stat;

    // accept rules and registered outputs
    tmu_ctrl ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .tag_in     (tag_in),
        .pop_in     (pop_in),
        .occupancy  (occupancy),
        .head_tag   (head_tag),
        .next_tag   (next_tag),
        .wr_en      (wr_en),
        .wr_qid     (wr_qid),
        .wr_tag     (wr_tag),
        .rd_en      (rd_en),
        .rd_qid     (rd_qid),
        .push_stat  (push_stat),
        .pop_stat   (pop_stat),
        .prc_tag    (prc_tag),
        .pfs_update (pfs_update),
        .drop       (drop),
        .pop_err    (pop_err)
    );

    // per queue tag buffers
    tag_queue_bank bank_i (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr_qid    (wr_qid),
        .wr_tag    (wr_tag),
        .rd_en     (rd_en),
        .rd_qid    (rd_qid),
        .occupancy (occupancy),
        .head_tag  (head_tag),
        .next_tag  (next_tag)
    );

    // segment and eop counters, hoq view
    queue_stats stats_i (
        .clk       (clk),
        .rst       (rst),
        .push_stat (push_stat),
        .pop_stat  (pop_stat),
        .head_tag  (head_tag),
        .seg_count (seg_count),
        .eop_count (eop_count),
        .hoq_info  (hoq_info)
    );

endmodule : tmu

// File: test/tmu_ref_model.svh
`ifndef TMU_REF_MODEL_SVH
`define TMU_REF_MODEL_SVH

// reference queues, one per port and class pair
tag_t model_q [`TMU_QUEUES][$];

// queue number from port and class
function automatic int queue_index(logic [`TMU_PORT_W-1:0] port, logic [`TMU_TC_W-1:0] tc);
    return int'(port) * `TMU_TCS + int'(tc);
endfunction

function automatic void model_reset();
    for (int q = 0; q < `TMU_QUEUES; q++) begin
        model_q[q].delete();
    end
endfunction

// one cycle of ring tag and scheduler pop, returns next-cycle outputs
function automatic void model_step(input tag_t tin, input pop_req_t pin,
                                   output tag_t exp_tag, output pfs_update_t exp_update,
                                   output logic exp_drop_o, output logic exp_err_o);
    int   pq;
    int   tq;
    logic pop_take;
    logic push_take;
    pq = queue_index(pin.port, pin.tc);
    tq = queue_index(tin.port, tin.tc);
    // empty pop rejected even if a push lands this cycle
    pop_take  = pin.valid && (model_q[pq].size() > 0);
    // a full queue takes the push only when it is popped too
    push_take = tin.valid && ((model_q[tq].size() < `TMU_DEPTH) || (pop_take && pq == tq));
    exp_tag    = '0;
    exp_update = '0;
    if (pop_take) begin
        exp_tag = model_q[pq].pop_front();
    end
    if (push_take) begin
        model_q[tq].push_back(tin);
    end
    if (pop_take) begin
        exp_update.valid    = 1'b1;
        exp_update.port     = pin.port;
        exp_update.tc       = pin.tc;
        // new head after both ops, 0 once empty
        exp_update.head_len = (model_q[pq].size() > 0) ? model_q[pq][0].len : len_t'(0);
    end
    exp_drop_o = tin.valid && !push_take;
    exp_err_o  = pin.valid && !pop_take;
endfunction

// sum of stored lengths
function automatic seg_cnt_t model_seg(int q);
    seg_cnt_t s;
    s = '0;
    for (int i = 0; i < model_q[q].size(); i++) begin
        s += seg_cnt_t'(model_q[q][i].len);
    end
    return s;
endfunction

// stored end-of-packet tags
function automatic eop_cnt_t model_eop(int q);
    eop_cnt_t e;
    e = '0;
    for (int i = 0; i < model_q[q].size(); i++) begin
        e += eop_cnt_t'(model_q[q][i].eop);
    end
    return e;
endfunction

function automatic hoq_info_t model_hoq(int q);
    hoq_info_t h;
    h            = '0;
    h.eop_in_buf = (model_eop(q) != '0);
    if (model_q[q].size() > 0) begin
        h.valid = 1'b1;
        h.len   = model_q[q][0].len;
    end
    return h;
endfunction

`endif

// File: test/tmu_tb.sv
`include "tmu_defines.svh"

module tmu_tb
import tmu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int STIM_CYCLES    = 2500;
    // stimulus plus reset and drain margin
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 500;
    // fill and drain phases alternate
    localparam int PHASE_LEN      = 250;

    logic                        clk;
    logic                        rst;
    tag_t                        tag_in;
    pop_req_t                    pop_in;
    tag_t                        prc_tag;
    pfs_update_t                 pfs_update;
    hoq_info_t [`TMU_QUEUES-1:0] hoq_info;
    seg_cnt_t [`TMU_QUEUES-1:0]  seg_count;
    eop_cnt_t [`TMU_QUEUES-1:0]  eop_count;
    logic                        drop;
    logic                        pop_err;

    integer seed;
    int     cycle_cnt = 0;
    int     err_tag = 0;
    int     err_upd = 0;
    int     err_hoq = 0;
    int     err_cnt = 0;
    int     err_flag = 0;
    int     err_other = 0;
    int     n_drop = 0;
    int     n_pop = 0;
    int     n_pop_err = 0;

    // expectations for the strobes driven last cycle
    tag_t        exp_prc;
    pfs_update_t exp_upd;
    logic        exp_drop;
    logic        exp_err;

    `include "tmu_ref_model.svh"

    tmu dut_i (
        .clk        (clk),
        .rst        (rst),
        .tag_in     (tag_in),
        .pop_in     (pop_in),
        .prc_tag    (prc_tag),
        .pfs_update (pfs_update),
        .hoq_info   (hoq_info),
        .seg_count  (seg_count),
        .eop_count  (eop_count),
        .drop       (drop),
        .pop_err    (pop_err)
    );

    // 8 ns period
    always #4 clk = ~clk;

    // ------------------------------------------------------------------------
    // run limit
    // ------------------------------------------------------------------------

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", cycle_cnt);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------

    // fields of an invalid tag carry no meaning
    task automatic check_tag(input string name, input tag_t act, input tag_t exp);
        if (exp.valid ? (act !== exp) : (act.valid !== 1'b0)) begin
            err_tag++;
            $display("Mismatch at %0t: %s actual %h expected %h", $time, name, act, exp);
        end
    endtask

    task automatic check_update(input string name, input pfs_update_t act,
                                input pfs_update_t exp);
        if (exp.valid ? (act !== exp) : (act.valid !== 1'b0)) begin
            err_upd++;
            $display("Mismatch at %0t: %s actual %h expected %h", $time, name, act, exp);
        end
    endtask

    task automatic check_hoq(input string name, input hoq_info_t act, input hoq_info_t exp);
        if (act !== exp) begin
            err_hoq++;
            $display("Mismatch at %0t: %s actual %h expected %h", $time, name, act, exp);
        end
    endtask

    task automatic check_count(input string name, input seg_cnt_t act, input seg_cnt_t exp);
        if (act !== exp) begin
            err_cnt++;
            $display("Mismatch at %0t: %s actual %0d expected %0d", $time, name, act, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            err_flag++;
            $display("Mismatch at %0t: %s actual %b expected %b", $time, name, act, exp);
        end
    endtask

    // all outputs against the model, one cycle after the strobes
    task automatic check_outputs();
        check_tag("prc_tag", prc_tag, exp_prc);
        check_update("pfs_update", pfs_update, exp_upd);
        check_flag("drop", drop, exp_drop);
        check_flag("pop_err", pop_err, exp_err);
        for (int q = 0; q < `TMU_QUEUES; q++) begin
            check_count($sformatf("seg_count[%0d]", q), seg_count[q], model_seg(q));
            check_count($sformatf("eop_count[%0d]", q), seg_cnt_t'(eop_count[q]),
                        seg_cnt_t'(model_eop(q)));
            check_hoq($sformatf("hoq_info[%0d]", q), hoq_info[q], model_hoq(q));
        end
    endtask

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic chance(int pct);
        return int'(rand_word() % 32'd100) < pct;
    endfunction

    // apply to model, tally, then drive
    task automatic drive_strobes(input tag_t t, input pop_req_t p);
        model_step(t, p, exp_prc, exp_upd, exp_drop, exp_err);
        if (exp_drop) n_drop++;
        if (exp_err) n_pop_err++;
        if (exp_upd.valid) n_pop++;
        tag_in = t;
        pop_in = p;
    endtask

    task automatic drive_random(input int n);
        tag_t        t;
        pop_req_t    p;
        logic [31:0] r;
        int          push_pct;
        int          pop_pct;
        // fill phase pushes hard, drain phase pops hard
        if ((n / PHASE_LEN) % 2 == 0) begin
            push_pct = 85;
            pop_pct  = 25;
        end else begin
            push_pct = 25;
            pop_pct  = 85;
        end
        r       = rand_word();
        t.valid = chance(push_pct);
        t.port  = r[`TMU_PORT_W-1:0];
        t.tc    = r[8+`TMU_TC_W-1:8];
        t.eop   = r[16];
        t.len   = r[24+`TMU_LEN_W-1:24];
        // zero length is not a legal tag
        if (t.len == '0) t.len = len_t'(1);
        r       = rand_word();
        p.valid = chance(pop_pct);
        p.port  = r[`TMU_PORT_W-1:0];
        p.tc    = r[8+`TMU_TC_W-1:8];
        drive_strobes(t, p);
    endtask

    initial begin
        int total;
        seed   = 32'ha83b73eb;
        clk    = 1'b0;
        rst    = 1'b1;
        tag_in = '0;
        pop_in = '0;
        exp_prc  = '0;
        exp_upd  = '0;
        exp_drop = 1'b0;
        exp_err  = 1'b0;
        model_reset();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        // check last cycle's strobes, then drive the next ones
        for (int n = 0; n < STIM_CYCLES; n++) begin
            @(posedge clk);
            #1;
            check_outputs();
            drive_random(n);
        end
        @(posedge clk);
        #1;
        check_outputs();
        drive_strobes('0, '0);
        @(posedge clk);
        #1;
        check_outputs();
        // stimulus must have reached both queue limits
        if (n_drop == 0) begin
            err_other++;
            $display("no push was dropped, full queues were never reached");
        end
        if (n_pop_err == 0) begin
            err_other++;
            $display("no pop of an empty queue was seen");
        end
        $display("accepted pops %0d, drops %0d, empty pops %0d", n_pop, n_drop, n_pop_err);
        total = err_tag + err_upd + err_hoq + err_cnt + err_flag + err_other;
        $display("errors: tag %0d update %0d hoq %0d count %0d flag %0d other %0d",
                 err_tag, err_upd, err_hoq, err_cnt, err_flag, err_other);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : tmu_tb

// File: project.f
+incdir+logic
+incdir+test
logic/tmu_pkg.sv
logic/tag_queue_bank.sv
logic/queue_stats.sv
logic/tmu_ctrl.sv
logic/tmu.sv
test/tmu_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the tmu testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir
FAIL_MSG='*** TEST FAILED ***'
PASS_MSG='*** TEST PASSED ***'

verilator --binary --timing --assert -j 0 \
    -f project.f --top-module tmu_tb --Mdir "$BUILD" -o tmu_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$BUILD/tmu_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q -F "$FAIL_MSG" "$LOG"; then
    echo "simulation reported failure, see $LOG"
    exit 1
fi

if ! grep -q -F "$PASS_MSG" "$LOG"; then
    echo "simulation ended without a verdict, see $LOG"
    exit 1
fi

exit 0
